//--- dv/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts #(
  parameter int buffer_depth = 8
) (
  input logic clock,
  input logic reset,
  input logic [$clog2(buffer_depth)+2:0] count,
  input logic accept,
  input logic clear,
  input logic ready0,
  input logic ready1,
  input logic [31:0] pc0,
  input logic [31:0] pc1,
  input logic [31:0] instr0,
  input logic stall
);

  int failures = 0;

  occupancy_bound: assert property (@(posedge clock) disable iff (!reset)
    int'(count) <= 4 * buffer_depth)
    else begin
      failures++;
      $error("buffer occupancy above bank capacity");
    end

  // slot 1 starts right after the instruction in slot 0
  ready_order: assert property (@(posedge clock) disable iff (!reset)
    ready1 |-> ready0 && pc1 == pc0 + ((instr0[1:0] == 2'b11) ? 32'd4 : 32'd2))
    else begin
      failures++;
      $error("ready1 high without ready0 or with a pc gap after slot 0");
    end

  // occupancy can only grow while nothing is extracted
  stall_blocks_extract: assert property (@(posedge clock) disable iff (!reset)
    stall && !clear |=> count >= $past(count))
    else begin
      failures++;
      $error("instruction extracted during stall");
    end

  // first packet after a redirect is taken in the next cycle
  clear_blocks_accept: assert property (@(posedge clock) disable iff (!reset)
    clear |=> !$past(accept) && (accept || clear))
    else begin
      failures++;
      $error("packet accepted in a clear cycle or first packet not taken after it");
    end

endmodule

bind instr_buffer fetch_asserts #(
  .buffer_depth(buffer_depth)
) buffer_asserts_inst (
  .clock(clock),
  .reset(reset),
  .count(count_q),
  .accept(fetch.accept),
  .clear(fetch.clear),
  .ready0(issue.ready0),
  .ready1(issue.ready1),
  .pc0(issue.pc0),
  .pc1(issue.pc1),
  .instr0(issue.instr0),
  .stall(issue.stall)
);

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam int buffer_depth = 8;
  localparam int mem_depth = 64;
  localparam int mem_bits = $clog2(mem_depth);
  localparam int stream_size = mem_depth * 4;

  logic clock;
  logic reset;
  logic mem_wen;
  logic [mem_bits-1:0] mem_addr;
  logic [packet_width-1:0] mem_wdata;
  logic redirect;
  logic [31:0] redirect_pc;
  logic hold;
  logic issue_valid0;
  logic issue_valid1;
  logic [31:0] issue_pc0;
  logic [31:0] issue_pc1;
  logic [31:0] issue_instr0;
  logic [31:0] issue_instr1;
  instr_class_t issue_class0;
  instr_class_t issue_class1;

  // program as a halfword stream, four halfwords per memory word
  logic [15:0] prog_hw [stream_size];
  logic [31:0] exp_pc;
  logic started;
  int issued_count;
  string test_name;
  int pc_errors;
  int instr_errors;
  int class_errors;
  int other_errors;
  int assert_errors;

  fetch_top #(
    .buffer_depth(buffer_depth),
    .mem_depth(mem_depth)
  ) fetch_top_inst (
    .clock(clock),
    .reset(reset),
    .mem_wen(mem_wen),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .hold(hold),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_class0(issue_class0),
    .issue_class1(issue_class1)
  );

  always #50 clock = ~clock;

  function automatic logic [15:0] halfword_at(input logic [31:0] pc);
    return prog_hw[pc[mem_bits+2:1]];
  endfunction

  function automatic logic [31:0] expected_instr(input logic [31:0] pc);
    logic [15:0] low_hw;
    low_hw = halfword_at(pc);
    if (low_hw[1:0] != 2'b11) begin
      return {16'h0000, low_hw};
    end
    return {halfword_at(pc + 32'd2), low_hw};
  endfunction

  // major opcodes of the base isa
  function automatic instr_class_t expected_class(input logic [31:0] instr);
    if (instr[1:0] != 2'b11) begin
      return class_compressed;
    end
    case (instr[6:0])
      7'b0110011, 7'b0010011: return class_alu;
      7'b0000011: return class_load;
      7'b0100011: return class_store;
      7'b1100011: return class_branch;
      7'b1101111, 7'b1100111: return class_jump;
      7'b1110011: return class_system;
      default: return class_other;
    endcase
  endfunction

  function automatic logic [31:0] random_pc(input logic unaligned);
    logic [31:0] pc;
    pc = $urandom & 32'h0000_0ff8;
    if (unaligned) begin
      pc[2:1] = 2'(1 + $urandom % 3);
    end else begin
      pc[2:1] = 2'($urandom % 4);
    end
    return pc;
  endfunction

  task automatic check_pc(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (expected !== actual) begin
      pc_errors++;
      $display("ERROR %s pc: expected %h actual %h", what, expected, actual);
    end
  endtask

  task automatic check_instr(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      instr_errors++;
      $display("ERROR %s instr: expected %h actual %h", what, expected, actual);
    end
  endtask

  task automatic check_class(input string what, input instr_class_t expected,
                             input instr_class_t actual);
    if (expected !== actual) begin
      class_errors++;
      $display("ERROR %s class: expected %s actual %s", what, expected.name(), actual.name());
    end
  endtask

  task automatic take_issued(input string slot, input logic [31:0] pc, input logic [31:0] instr,
                             input instr_class_t cls);
    logic [31:0] exp_instr;
    exp_instr = expected_instr(exp_pc);
    check_pc({test_name, " ", slot}, exp_pc, pc);
    check_instr({test_name, " ", slot}, exp_instr, instr);
    check_class({test_name, " ", slot}, expected_class(exp_instr), cls);
    exp_pc = exp_pc + ((exp_instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
    issued_count++;
  endtask

  // outputs and hold are stable at the falling edge
  always @(negedge clock) begin
    if (reset) begin
      if (!started && (issue_valid0 || issue_valid1)) begin
        other_errors++;
        $display("issue output went valid before the first redirect");
      end
      if (started && !hold) begin
        if (issue_valid1 && !issue_valid0) begin
          other_errors++;
          $display("slot 1 was valid while slot 0 was not");
        end
        if (issue_valid0) begin
          take_issued("slot0", issue_pc0, issue_instr0, issue_class0);
        end
        if (issue_valid1) begin
          take_issued("slot1", issue_pc1, issue_instr1, issue_class1);
        end
      end
      // outputs of the redirect cycle still belong to the old stream
      if (redirect) begin
        started = 1'b1;
        exp_pc = redirect_pc;
      end
    end
  end

  task automatic build_program();
    int idx;
    logic [31:0] word;
    idx = 0;
    while (idx < stream_size) begin
      word = $urandom;
      if (($urandom % 2 == 0) || idx == stream_size - 1) begin
        if (word[1:0] == 2'b11) begin
          word[1:0] = 2'($urandom % 3);
        end
        prog_hw[idx] = word[15:0];
        idx++;
      end else begin
        word[1:0] = 2'b11;
        prog_hw[idx] = word[15:0];
        prog_hw[idx+1] = word[31:16];
        idx += 2;
      end
    end
  endtask

  task automatic load_program();
    for (int w = 0; w < mem_depth; w++) begin
      @(posedge clock);
      mem_wen <= 1'b1;
      mem_addr <= mem_bits'(w);
      mem_wdata <= {prog_hw[4*w+3], prog_hw[4*w+2], prog_hw[4*w+1], prog_hw[4*w]};
    end
    @(posedge clock);
    mem_wen <= 1'b0;
  endtask

  task automatic do_redirect(input logic [31:0] pc);
    @(posedge clock);
    hold <= 1'b0;
    redirect <= 1'b1;
    redirect_pc <= pc;
    @(posedge clock);
    redirect <= 1'b0;
  endtask

  task automatic run_cycles(input int cycles, input int hold_percent);
    repeat (cycles) begin
      @(posedge clock);
      hold <= ($urandom % 100) < hold_percent;
    end
  endtask

  task automatic wait_issued(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (issued_count < target && cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    if (issued_count < target) begin
      other_errors++;
      $display("timeout in %s: %0d of %0d instructions issued", test_name, issued_count, target);
    end
  endtask

  initial begin
    void'($urandom(32'h73c1));
    clock = 1'b0;
    reset = 1'b0;
    mem_wen = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    hold = 1'b0;
    exp_pc = '0;
    started = 1'b0;
    issued_count = 0;
    pc_errors = 0;
    instr_errors = 0;
    class_errors = 0;
    other_errors = 0;
    test_name = "idle";
    build_program();
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    load_program();
    run_cycles(8, 0);

    test_name = "aligned";
    do_redirect(32'h0000_0040);
    wait_issued(issued_count + 60, 400);

    // mid-stream redirects to unaligned halfword offsets
    test_name = "unaligned";
    for (int i = 0; i < 12; i++) begin
      do_redirect(random_pc(1'b1));
      run_cycles($urandom % 12, 0);
    end
    wait_issued(issued_count + 30, 300);

    test_name = "hold";
    for (int i = 0; i < 6; i++) begin
      do_redirect(random_pc(1'b0));
      run_cycles(40, 50);
      // long hold lets the buffer fill up
      run_cycles(30, 100);
      run_cycles(1, 0);
      wait_issued(issued_count + 40, 400);
    end

    run_cycles(5, 0);
    assert_errors = fetch_top_inst.instr_buffer_inst.buffer_asserts_inst.failures;
    $display("errors: pc %0d, instr %0d, class %0d, other %0d, assertion %0d (%0d issued)",
             pc_errors, instr_errors, class_errors, other_errors, assert_errors, issued_count);
    if (pc_errors + instr_errors + class_errors + other_errors + assert_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/fetch_if.sv
`timescale 1ns/1ps

interface fetch_if import fetch_pkg::*; ();

  logic ready;
  logic clear;
  logic [31:0] pc;
  logic [packet_width-1:0] rdata;
  logic accept;

  modport producer (
    output ready,
    output clear,
    output pc,
    output rdata,
    input accept
  );

  modport buffer (
    input ready,
    input clear,
    input pc,
    input rdata,
    output accept
  );

endinterface

//--- rtl/fetch_pkg.sv
package fetch_pkg;

  localparam int packet_width = 64;
  localparam int entry_width = 48;

  typedef enum logic [2:0] {
    class_compressed,
    class_alu,
    class_load,
    class_store,
    class_branch,
    class_jump,
    class_system,
    class_other
  } instr_class_t;

  // rvc halfwords never have both low bits set
  function automatic logic is_compressed(input logic [15:0] halfword);
    return ~(&halfword[1:0]);
  endfunction

  function automatic instr_class_t classify_instr(input logic [31:0] instr);
    instr_class_t result;
    if (is_compressed(instr[15:0])) begin
      result = class_compressed;
    end else begin
      case (instr[6:2])
        5'b01100, 5'b00100: result = class_alu;
        5'b00000: result = class_load;
        5'b01000: result = class_store;
        5'b11000: result = class_branch;
        5'b11011, 5'b11001: result = class_jump;
        5'b11100: result = class_system;
        // lui, auipc, fence and the rest
        default: result = class_other;
      endcase
    end
    return result;
  endfunction

endpackage

//--- rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter int buffer_depth = 8,
  parameter int mem_depth = 64
) (
  input logic clock,
  input logic reset,
  input logic mem_wen,
  input logic [$clog2(mem_depth)-1:0] mem_addr,
  input logic [packet_width-1:0] mem_wdata,
  input logic redirect,
  input logic [31:0] redirect_pc,
  input logic hold,
  output logic issue_valid0,
  output logic issue_valid1,
  output logic [31:0] issue_pc0,
  output logic [31:0] issue_pc1,
  output logic [31:0] issue_instr0,
  output logic [31:0] issue_instr1,
  output instr_class_t issue_class0,
  output instr_class_t issue_class1
);

  fetch_if fetch_link ();
  issue_if issue_link ();

  fetch_unit #(
    .mem_depth(mem_depth)
  ) fetch_unit_inst (
    .clock(clock),
    .reset(reset),
    .mem_wen(mem_wen),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .fetch(fetch_link.producer)
  );

  instr_buffer #(
    .buffer_depth(buffer_depth)
  ) instr_buffer_inst (
    .clock(clock),
    .reset(reset),
    .fetch(fetch_link.buffer),
    .issue(issue_link.buffer)
  );

  issue_decode issue_decode_inst (
    .clock(clock),
    .reset(reset),
    .hold(hold),
    .issue(issue_link.decoder),
    .issue_valid0(issue_valid0),
    .issue_valid1(issue_valid1),
    .issue_pc0(issue_pc0),
    .issue_pc1(issue_pc1),
    .issue_instr0(issue_instr0),
    .issue_instr1(issue_instr1),
    .issue_class0(issue_class0),
    .issue_class1(issue_class1)
  );

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; #(
  parameter int mem_depth = 64
) (
  input logic clock,
  input logic reset,
  input logic mem_wen,
  input logic [$clog2(mem_depth)-1:0] mem_addr,
  input logic [packet_width-1:0] mem_wdata,
  input logic redirect,
  input logic [31:0] redirect_pc,
  fetch_if.producer fetch
);

  localparam int mem_bits = $clog2(mem_depth);

  logic [packet_width-1:0] mem [mem_depth];

  logic ready_q;
  logic [31:0] pc_q;
  logic [1:0] offset_q;

  always_ff @(posedge clock) begin
    if (mem_wen) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      ready_q <= 1'b0;
      pc_q <= '0;
      offset_q <= '0;
    end else if (redirect) begin
      ready_q <= 1'b1;
      pc_q <= {redirect_pc[31:3], 3'b000};
      offset_q <= redirect_pc[2:1];
    end else if (ready_q && fetch.accept) begin
      pc_q <= pc_q + 32'd8;
      offset_q <= 2'b00;
    end
  end

  // only the first packet after a redirect carries a halfword offset
  assign fetch.pc = {pc_q[31:3], offset_q, 1'b0};
  assign fetch.rdata = mem[pc_q[mem_bits+2:3]];
  assign fetch.ready = ready_q;
  assign fetch.clear = redirect;

endmodule

//--- rtl/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer import fetch_pkg::*; #(
  parameter int buffer_depth = 8
) (
  input logic clock,
  input logic reset,
  fetch_if.buffer fetch,
  issue_if.buffer issue
);

  localparam int addr_bits = $clog2(buffer_depth);
  localparam int ptr_bits = addr_bits + 2;
  localparam int cnt_bits = addr_bits + 3;
  localparam logic [cnt_bits-1:0] threshold = cnt_bits'(4 * buffer_depth - 8);

  // pointers and occupancy count halfwords
  logic [ptr_bits-1:0] wid_q;
  logic [ptr_bits-1:0] rid_q;
  logic [cnt_bits-1:0] count_q;
  logic align_q;
  logic full_q;

  logic [ptr_bits-1:0] wid_d;
  logic [ptr_bits-1:0] rid_d;
  logic [cnt_bits-1:0] count_d;
  logic align_d;

  logic wen;
  logic first;
  logic [ptr_bits-1:0] rid_eff;
  logic [cnt_bits-1:0] avail;
  logic [1:0] rd_offset;
  logic [addr_bits-1:0] row_base;
  logic [addr_bits-1:0] wrow;
  logic [addr_bits-1:0] raddr [4];
  logic [entry_width-1:0] bank_wdata [4];
  logic [entry_width-1:0] bank_rdata [4];
  logic [entry_width-1:0] rd [4];

  logic comp0;
  logic comp1;
  logic [1:0] len0;
  logic [1:0] len1;
  logic [2:0] consume;

  assign wen = fetch.ready & ~fetch.clear & ~full_q;
  assign fetch.accept = wen;
  assign first = align_q & wen;
  assign wrow = wid_q[ptr_bits-1:2];

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      bank_wdata[b] = {fetch.pc[31:3], 2'(b), 1'b0, fetch.rdata[16*b +: 16]};
    end
  end

  // first packet after a redirect starts reading at its pc offset
  assign rid_eff = first ? ptr_bits'(fetch.pc[2:1]) : rid_q;
  assign avail = count_q + (wen ? cnt_bits'(4) : '0) - (first ? cnt_bits'(fetch.pc[2:1]) : '0);
  assign rd_offset = rid_eff[1:0];
  assign row_base = rid_eff[ptr_bits-1:2];

  // banks below the offset already wrapped to the next row
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      raddr[b] = row_base + ((2'(b) < rd_offset) ? addr_bits'(1) : addr_bits'(0));
      rd[b] = bank_rdata[2'(b) + rd_offset];
    end
  end

  instr_buffer_banks #(
    .buffer_depth(buffer_depth)
  ) banks_inst (
    .clock(clock),
    .wen0(wen),
    .wen1(wen),
    .wen2(wen),
    .wen3(wen),
    .waddr0(wrow),
    .waddr1(wrow),
    .waddr2(wrow),
    .waddr3(wrow),
    .wdata0(bank_wdata[0]),
    .wdata1(bank_wdata[1]),
    .wdata2(bank_wdata[2]),
    .wdata3(bank_wdata[3]),
    .raddr0(raddr[0]),
    .raddr1(raddr[1]),
    .raddr2(raddr[2]),
    .raddr3(raddr[3]),
    .rdata0(bank_rdata[0]),
    .rdata1(bank_rdata[1]),
    .rdata2(bank_rdata[2]),
    .rdata3(bank_rdata[3])
  );

  always_comb begin
    comp0 = is_compressed(rd[0][15:0]);
    len0 = comp0 ? 2'd1 : 2'd2;
    comp1 = is_compressed(rd[len0][15:0]);
    len1 = comp1 ? 2'd1 : 2'd2;

    issue.ready0 = (avail >= cnt_bits'(len0)) & ~issue.stall & ~fetch.clear;
    issue.ready1 = issue.ready0 & (avail >= cnt_bits'(len0) + cnt_bits'(len1));

    issue.pc0 = rd[0][47:16];
    issue.instr0 = comp0 ? {16'h0000, rd[0][15:0]} : {rd[1][15:0], rd[0][15:0]};
    issue.pc1 = rd[len0][47:16];
    if (comp1) begin
      issue.instr1 = {16'h0000, rd[len0][15:0]};
    end else begin
      issue.instr1 = {rd[len0 + 2'd1][15:0], rd[len0][15:0]};
    end

    consume = '0;
    if (issue.ready0) begin
      consume = 3'(len0) + (issue.ready1 ? 3'(len1) : 3'd0);
    end
  end

  always_comb begin
    wid_d = wen ? wid_q + ptr_bits'(4) : wid_q;
    rid_d = rid_eff + ptr_bits'(consume);
    count_d = avail - cnt_bits'(consume);
    align_d = align_q & ~wen;
    if (fetch.clear) begin
      wid_d = '0;
      rid_d = '0;
      count_d = '0;
      align_d = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wid_q <= '0;
      rid_q <= '0;
      count_q <= '0;
      align_q <= 1'b0;
      full_q <= 1'b0;
    end else begin
      wid_q <= wid_d;
      rid_q <= rid_d;
      count_q <= count_d;
      align_q <= align_d;
      full_q <= count_d > threshold;
    end
  end

endmodule

//--- rtl/instr_buffer_banks.sv
`timescale 1ns/1ps

module instr_buffer_banks import fetch_pkg::*; #(
  parameter int buffer_depth = 8
) (
  input logic clock,
  input logic wen0,
  input logic wen1,
  input logic wen2,
  input logic wen3,
  input logic [$clog2(buffer_depth)-1:0] waddr0,
  input logic [$clog2(buffer_depth)-1:0] waddr1,
  input logic [$clog2(buffer_depth)-1:0] waddr2,
  input logic [$clog2(buffer_depth)-1:0] waddr3,
  input logic [entry_width-1:0] wdata0,
  input logic [entry_width-1:0] wdata1,
  input logic [entry_width-1:0] wdata2,
  input logic [entry_width-1:0] wdata3,
  input logic [$clog2(buffer_depth)-1:0] raddr0,
  input logic [$clog2(buffer_depth)-1:0] raddr1,
  input logic [$clog2(buffer_depth)-1:0] raddr2,
  input logic [$clog2(buffer_depth)-1:0] raddr3,
  output logic [entry_width-1:0] rdata0,
  output logic [entry_width-1:0] rdata1,
  output logic [entry_width-1:0] rdata2,
  output logic [entry_width-1:0] rdata3
);

  localparam int addr_bits = $clog2(buffer_depth);

  logic [3:0] wen;
  logic [addr_bits-1:0] waddr [4];
  logic [addr_bits-1:0] raddr [4];
  logic [entry_width-1:0] wdata [4];
  logic [entry_width-1:0] rdata [4];

  assign wen = {wen3, wen2, wen1, wen0};
  assign waddr = '{waddr0, waddr1, waddr2, waddr3};
  assign raddr = '{raddr0, raddr1, raddr2, raddr3};
  assign wdata = '{wdata0, wdata1, wdata2, wdata3};

  for (genvar b = 0; b < 4; b++) begin : g_bank
    logic [entry_width-1:0] mem [buffer_depth];

    always_ff @(posedge clock) begin
      if (wen[b]) begin
        mem[waddr[b]] <= wdata[b];
      end
    end

    // bypass lets a halfword be read in the cycle it is written
    assign rdata[b] = (wen[b] && raddr[b] == waddr[b]) ? wdata[b] : mem[raddr[b]];
  end

  assign rdata0 = rdata[0];
  assign rdata1 = rdata[1];
  assign rdata2 = rdata[2];
  assign rdata3 = rdata[3];

endmodule

//--- rtl/issue_decode.sv
`timescale 1ns/1ps

module issue_decode import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic hold,
  issue_if.decoder issue,
  output logic issue_valid0,
  output logic issue_valid1,
  output logic [31:0] issue_pc0,
  output logic [31:0] issue_pc1,
  output logic [31:0] issue_instr0,
  output logic [31:0] issue_instr1,
  output instr_class_t issue_class0,
  output instr_class_t issue_class1
);

  instr_class_t class0;
  instr_class_t class1;

  assign class0 = classify_instr(issue.instr0);
  assign class1 = classify_instr(issue.instr1);

  // buffer keeps its read pointer while outputs are held
  assign issue.stall = hold;

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
    end else if (!hold) begin
      issue_valid0 <= issue.ready0;
      issue_valid1 <= issue.ready1;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      issue_pc0 <= issue.pc0;
      issue_pc1 <= issue.pc1;
      issue_instr0 <= issue.instr0;
      issue_instr1 <= issue.instr1;
      issue_class0 <= class0;
      issue_class1 <= class1;
    end
  end

endmodule

//--- rtl/issue_if.sv
`timescale 1ns/1ps

interface issue_if ();

  logic ready0;
  logic ready1;
  logic [31:0] pc0;
  logic [31:0] pc1;
  logic [31:0] instr0;
  logic [31:0] instr1;
  logic stall;

  modport buffer (
    output ready0,
    output ready1,
    output pc0,
    output pc1,
    output instr0,
    output instr1,
    input stall
  );

  modport decoder (
    input ready0,
    input ready1,
    input pc0,
    input pc1,
    input instr0,
    input instr1,
    output stall
  );

endinterface

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module fetch_tb -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# keep running after an assertion error so the testbench can report it
output=$(./obj_dir/Vfetch_tb +verilator+error+limit+1000)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
  exit 0
fi
exit 1

//--- sim.f
rtl/fetch_pkg.sv
rtl/fetch_if.sv
rtl/issue_if.sv
rtl/fetch_unit.sv
rtl/instr_buffer_banks.sv
rtl/instr_buffer.sv
rtl/issue_decode.sv
rtl/fetch_top.sv
dv/fetch_asserts.sv
dv/fetch_tb.sv
